/* dv/mipsCore_tests.txt */
# I <instruction word, hex>          program words, loaded from address 0 in order
# W <register, hex> <value, hex>     expected writebacks, in retirement order
I 20010005  # addi r1, r0, 5
W 01 00000005
I 2002FFFD  # addi r2, r0, -3
W 02 FFFFFFFD
I 00221820  # add r3, r1, r2
W 03 00000002
I 00222022  # sub r4, r1, r2
W 04 00000008
I 0041282A  # slt r5, r2, r1
W 05 00000001
I 0022302A  # slt r6, r1, r2
W 06 00000000
I 00443824  # and r7, r2, r4
W 07 00000008
I 00E14025  # or r8, r7, r1
W 08 0000000D
I 3049FF0F  # andi r9, r2, 0xff0f
W 09 0000FF0D
I 340A8001  # ori r10, r0, 0x8001
W 0A 00008001
I 3C0B1234  # lui r11, 0x1234
W 0B 12340000
I 00016100  # sll r12, r1, 4
W 0C 00000050
I 356D80F0  # ori r13, r11, 0x80f0
W 0D 123480F0
I AC0D0003  # sw r13, 3(r0)
I 8C0E0003  # lw r14, 3(r0)
W 0E 123480F0
I 840F0003  # lh r15, 3(r0)
W 0F FFFF80F0
I 80100003  # lb r16, 3(r0)
W 10 FFFFFFF0
I 02018820  # add r17, r16, r1
W 11 FFFFFFF5
I 20200007  # addi r0, r1, 7
I 00019020  # add r18, r0, r1
W 12 00000005
I 12410001  # beq r18, r1, +1
I 20130BAD  # addi r19, r0, 0xbad
I 16410001  # bne r18, r1, +1
I 20130077  # addi r19, r0, 0x77
W 13 00000077
I 12600001  # beq r19, r0, +1
I 8C140003  # lw r20, 3(r0)
W 14 123480F0
I 16800001  # bne r20, r0, +1
I 20150BAD  # addi r21, r0, 0xbad
I 0800001E  # j 30
I 20160BAD  # addi r22, r0, 0xbad
I 22970001  # addi r23, r20, 1
W 17 123480F1
I FC000000  # eop
I 20180BAD  # addi r24, r0, 0xbad

/* build.f */
+incdir+common
common/mipsPkg.sv
src/hazardUnit.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
memory/memoryStage.sv
src/mipsCore.sv
dv/mipsCoreTb.sv

/* Makefile */
TOP := mipsCoreTb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

lint:
	verilator --lint-only --timing --assert --top-module mipsCore -f build.f

clean:
	rm -rf obj_dir $(LOG)

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCoreTb;

	// Cycles watched for stray writebacks once halted
	localparam int QuietCycles = 8;

	// One expected retirement
	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
		logic [`DATA_WIDTH-1:0]     value;
	} wbExpectT;

	logic                       clk;
	logic                       rstN;
	logic                       start;
	logic                       imemWe;
	logic [`PC_WIDTH-1:0]       imemAddr;
	logic [`DATA_WIDTH-1:0]     imemData;
	logic                       wbValid;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`DATA_WIDTH-1:0]     wbData;
	logic                       halted;

	logic [`DATA_WIDTH-1:0] progWords [$];
	wbExpectT               expQ [$];
	int                     wbCount = 0;
	int                     cycleCount = 0;
	int                     cycleLimit = 100;

	mipsCore u_mipsCore (
		.clk      (clk),
		.rstN     (rstN),
		.start    (start),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.halted   (halted)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic failRun();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h",
				$time, name, actual, expected);
			failRun();
		end
	endtask

	// I lines hold program words and W lines a register and its value
	task automatic readTests();
		int       fd;
		int       count;
		string    line;
		string    rest;
		logic [31:0] a;
		logic [31:0] b;
		wbExpectT entry;
		fd = $fopen("dv/mipsCore_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file dv/mipsCore_tests.txt");
			failRun();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && (line[0] == "I" || line[0] == "W")) begin
				rest = line.substr(1, line.len() - 1);
				count = $sscanf(rest, "%h %h", a, b);
				if (line[0] == "I" && count >= 1) begin
					progWords.push_back(a);
				end else if (line[0] == "W" && count >= 2) begin
					entry.writeReg = a[`REG_ADDR_WIDTH-1:0];
					entry.value = b;
					expQ.push_back(entry);
				end else begin
					$display("Malformed line in the test file: %s", line);
					failRun();
				end
			end
		end
		$fclose(fd);
		if (progWords.size() == 0 || progWords.size() > `IMEM_DEPTH) begin
			$display("Program size %0d does not fit the instruction memory",
				progWords.size());
			failRun();
		end
	endtask

	// One word per clock through the load port
	task automatic loadProgram();
		foreach (progWords[i]) begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= `PC_WIDTH'(i);
			imemData <= progWords[i];
		end
		@(posedge clk);
		imemWe <= 1'b0;
		start <= 1'b1;
	endtask

	//////////////////////////////
	// Writeback scoreboard
	//////////////////////////////

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rstN === 1'b1 && wbValid === 1'b1) begin
			if (halted === 1'b1) begin
				$display("A writeback to r%0d was reported after halt", wbReg);
				failRun();
			end else if (wbCount >= expQ.size()) begin
				$display("More writebacks than the %0d expected", expQ.size());
				failRun();
			end else begin
				checkValue("wbReg", 32'(wbReg), 32'(expQ[wbCount].writeReg));
				checkValue("wbData", wbData, expQ[wbCount].value);
				wbCount++;
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the core never halted", cycleCount);
			failRun();
		end
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		readTests();
		cycleLimit = 20 * progWords.size() + 100;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		loadProgram();
		wait (halted === 1'b1);
		// Halted holds and nothing retires after it
		repeat (QuietCycles) begin
			@(negedge clk);
			checkValue("halted", 32'(halted), 32'd1);
		end
		if (wbCount == expQ.size()) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Halted after %0d of %0d expected writebacks", wbCount, expQ.size());
			failRun();
		end
	end

endmodule

/* src/mipsCore.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCore (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       start,
	input  logic                       imemWe,
	input  logic [`PC_WIDTH-1:0]       imemAddr,
	input  logic [`DATA_WIDTH-1:0]     imemData,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData,
	output logic                       halted
);

	// Pipeline registers
	mipsPkg::ifIdT  ifId;
	mipsPkg::idExT  idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;

	// Decode to fetch
	logic                 redirect;
	logic [`PC_WIDTH-1:0] redirectPc;
	logic                 haltFetch;

	// Hazard unit inputs and outputs
	logic [`REG_ADDR_WIDTH-1:0] rs;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic [`REG_ADDR_WIDTH-1:0] writeRegEx;
	logic                       branch;
	logic                       stallFetch;
	logic                       stallDecode;
	logic                       flushEx;
	logic                       fwdDecA;
	logic                       fwdDecB;
	mipsPkg::fwdSelT            fwdExA;
	mipsPkg::fwdSelT            fwdExB;

	fetchStage u_fetchStage (
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.imemWe     (imemWe),
		.imemAddr   (imemAddr),
		.imemData   (imemData),
		.stallFetch (stallFetch),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.haltFetch  (haltFetch),
		.ifId       (ifId)
	);

	decodeStage u_decodeStage (
		.clk         (clk),
		.rstN        (rstN),
		.ifId        (ifId),
		.memWb       (memWb),
		.exMemAluOut (exMem.aluOut),
		.fwdDecA     (fwdDecA),
		.fwdDecB     (fwdDecB),
		.stallDecode (stallDecode),
		.flushEx     (flushEx),
		.redirect    (redirect),
		.redirectPc  (redirectPc),
		.haltFetch   (haltFetch),
		.rs          (rs),
		.rt          (rt),
		.branch      (branch),
		.idEx        (idEx)
	);

	executeStage u_executeStage (
		.clk         (clk),
		.rstN        (rstN),
		.idEx        (idEx),
		.fwdExA      (fwdExA),
		.fwdExB      (fwdExB),
		.exMemAluOut (exMem.aluOut),
		.wbResult    (memWb.result),
		.exMem       (exMem),
		.writeRegEx  (writeRegEx)
	);

	memoryStage u_memoryStage (
		.clk    (clk),
		.rstN   (rstN),
		.exMem  (exMem),
		.memWb  (memWb),
		.halted (halted)
	);

	hazardUnit u_hazardUnit (
		.rs          (rs),
		.rt          (rt),
		.branch      (branch),
		.idEx        (idEx),
		.writeRegEx  (writeRegEx),
		.exMem       (exMem),
		.memWb       (memWb),
		.stallFetch  (stallFetch),
		.stallDecode (stallDecode),
		.flushEx     (flushEx),
		.fwdDecA     (fwdDecA),
		.fwdDecB     (fwdDecB),
		.fwdExA      (fwdExA),
		.fwdExB      (fwdExB)
	);

	// Retirement report, writes to r0 are not reported
	assign wbValid = memWb.valid && memWb.regWrite && (memWb.writeReg != '0);
	assign wbReg = memWb.writeReg;
	assign wbData = memWb.result;

endmodule

/* memory/memoryStage.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module memoryStage (
	input  logic           clk,
	input  logic           rstN,
	input  mipsPkg::exMemT exMem,
	output mipsPkg::memWbT memWb,
	output logic           halted
);

	localparam int DmemAddrW = $clog2(`DMEM_DEPTH);

	logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];
	logic [DmemAddrW-1:0]   addr;
	logic                   memWe;
	logic [`DATA_WIDTH-1:0] rawData;
	logic [`DATA_WIDTH-1:0] loadData;

	// Word addressed, whole-word stores only
	assign addr = exMem.aluOut[DmemAddrW-1:0];
	assign memWe = exMem.valid && exMem.ctrl.memWrite;

	always_ff @(posedge clk) begin
		if (memWe) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	// Asynchronous read
	assign rawData = dmem[addr];

	//////////////////////////////
	// Load mask
	//////////////////////////////

	always_comb begin
		case (exMem.ctrl.loadWidth)
			// Low half, sign extended
			mipsPkg::LOAD_HALF: loadData = {{(`DATA_WIDTH-16){rawData[15]}}, rawData[15:0]};
			// Low byte, sign extended
			mipsPkg::LOAD_BYTE: loadData = {{(`DATA_WIDTH-8){rawData[7]}}, rawData[7:0]};
			default: loadData = rawData;
		endcase
	end

	// MEM/WB register, result already chosen
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
			halted <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.valid && exMem.ctrl.regWrite;
			memWb.eop <= exMem.valid && exMem.ctrl.eop;
			memWb.writeReg <= exMem.writeReg;
			memWb.result <= exMem.ctrl.memToReg ? loadData : exMem.aluOut;
			// Set as eop leaves writeback, held until reset
			if (memWb.valid && memWb.eop) begin
				halted <= 1'b1;
			end
		end
	end

	// Decoder never marks a store as writing a register
	assert property (@(posedge clk) disable iff (!rstN)
		memWe |-> !exMem.ctrl.regWrite);

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module executeStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  mipsPkg::idExT              idEx,
	input  mipsPkg::fwdSelT            fwdExA,
	input  mipsPkg::fwdSelT            fwdExB,
	input  logic [`DATA_WIDTH-1:0]     exMemAluOut,
	input  logic [`DATA_WIDTH-1:0]     wbResult,
	output mipsPkg::exMemT             exMem,
	output logic [`REG_ADDR_WIDTH-1:0] writeRegEx
);

	localparam int ShiftW = $clog2(`DATA_WIDTH);

	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluOut;

	// Operand source per forwarding select
	function automatic logic [`DATA_WIDTH-1:0] fwdMux(
		input mipsPkg::fwdSelT        sel,
		input logic [`DATA_WIDTH-1:0] regVal,
		input logic [`DATA_WIDTH-1:0] memVal,
		input logic [`DATA_WIDTH-1:0] wbVal
	);
		case (sel)
			mipsPkg::FWD_MEM: return memVal;
			mipsPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(fwdExA, idEx.readA, exMemAluOut, wbResult);
	assign srcB = fwdMux(fwdExB, idEx.readB, exMemAluOut, wbResult);

	// lui shifts by a constant, sll by shamt
	assign opA = idEx.ctrl.loadImm ? `DATA_WIDTH'(`LUI_SHIFT) :
		idEx.ctrl.aluShiftImm ? `DATA_WIDTH'(idEx.shamt) : srcA;
	assign opB = idEx.ctrl.aluSrc ? idEx.imm : srcB;

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::ALU_SUB: aluOut = opA - opB;
			mipsPkg::ALU_AND: aluOut = opA & opB;
			mipsPkg::ALU_OR: aluOut = opA | opB;
			// Signed compare
			mipsPkg::ALU_SLT: aluOut = `DATA_WIDTH'($signed(opA) < $signed(opB));
			// B shifted by A
			mipsPkg::ALU_SLL: aluOut = opB << opA[ShiftW-1:0];
			default: aluOut = opA + opB;
		endcase
	end

	// rd for R-type, rt otherwise
	assign writeRegEx = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	// EX/MEM register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.ctrl <= idEx.ctrl;
			exMem.writeReg <= writeRegEx;
			exMem.aluOut <= aluOut;
			// Store data must see forwarded rt
			exMem.storeData <= srcB;
		end
	end

endmodule

/* decode/decodeStage.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module decodeStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  mipsPkg::ifIdT              ifId,
	input  mipsPkg::memWbT             memWb,
	input  logic [`DATA_WIDTH-1:0]     exMemAluOut,
	input  logic                       fwdDecA,
	input  logic                       fwdDecB,
	input  logic                       stallDecode,
	input  logic                       flushEx,
	output logic                       redirect,
	output logic [`PC_WIDTH-1:0]       redirectPc,
	output logic                       haltFetch,
	output logic [`REG_ADDR_WIDTH-1:0] rs,
	output logic [`REG_ADDR_WIDTH-1:0] rt,
	output logic                       branch,
	output mipsPkg::idExT              idEx
);

	mipsPkg::instrT         instr;
	mipsPkg::ctrlT          ctrl;
	logic                   isBranch;
	logic                   branchNe;
	logic                   isJump;
	logic                   zeroExt;
	logic                   usesRt;
	logic                   taken;
	logic [`DATA_WIDTH-1:0] readA;
	logic [`DATA_WIDTH-1:0] readB;
	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] imm;

	assign instr = ifId.instr;

	regFile u_regFile (
		.clk       (clk),
		.rstN      (rstN),
		.readAddrA (instr.r.rs),
		.readAddrB (instr.r.rt),
		.writeEn   (memWb.valid && memWb.regWrite),
		.writeAddr (memWb.writeReg),
		.writeData (memWb.result),
		.readDataA (readA),
		.readDataB (readB)
	);

	//////////////////////////////
	// Control decoder
	//////////////////////////////

	always_comb begin
		// A cleared word is an add with no side effects
		ctrl = '0;
		isBranch = 1'b0;
		branchNe = 1'b0;
		isJump = 1'b0;
		zeroExt = 1'b0;
		usesRt = 1'b0;
		case (instr.r.opcode)
			mipsPkg::OP_RTYPE: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				usesRt = 1'b1;
				case (instr.r.funct)
					mipsPkg::FN_ADD: ctrl.aluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB: ctrl.aluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: ctrl.aluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_SLT: ctrl.aluOp = mipsPkg::ALU_SLT;
					mipsPkg::FN_SLL: begin
						ctrl.aluOp = mipsPkg::ALU_SLL;
						ctrl.aluShiftImm = 1'b1;
					end
					// Unknown funct retires as a no-op
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			mipsPkg::OP_ADDI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::OP_ANDI, mipsPkg::OP_ORI: begin
				ctrl.aluOp = (instr.i.opcode == mipsPkg::OP_ANDI) ?
					mipsPkg::ALU_AND : mipsPkg::ALU_OR;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				zeroExt = 1'b1;
			end
			// Immediate shifted up by the ALU
			mipsPkg::OP_LUI: begin
				ctrl.aluOp = mipsPkg::ALU_SLL;
				ctrl.aluSrc = 1'b1;
				ctrl.loadImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::OP_LW, mipsPkg::OP_LH, mipsPkg::OP_LB: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				if (instr.i.opcode == mipsPkg::OP_LH) begin
					ctrl.loadWidth = mipsPkg::LOAD_HALF;
				end else if (instr.i.opcode == mipsPkg::OP_LB) begin
					ctrl.loadWidth = mipsPkg::LOAD_BYTE;
				end
			end
			mipsPkg::OP_SW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				usesRt = 1'b1;
			end
			mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
				isBranch = 1'b1;
				branchNe = (instr.i.opcode == mipsPkg::OP_BNE);
				usesRt = 1'b1;
			end
			mipsPkg::OP_J: isJump = 1'b1;
			mipsPkg::OP_EOP: ctrl.eop = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// andi and ori take the immediate unsigned
	assign imm = zeroExt ? {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr.i.imm} :
		{{(`DATA_WIDTH-`IMM_WIDTH){instr.i.imm[`IMM_WIDTH-1]}}, instr.i.imm};

	//////////////////////////////
	// Branch and jump
	//////////////////////////////

	assign srcA = fwdDecA ? exMemAluOut : readA;
	assign srcB = fwdDecB ? exMemAluOut : readB;
	assign taken = branchNe ? (srcA != srcB) : (srcA == srcB);

	// Operands are stale while stalled
	assign redirect = ifId.valid && !stallDecode && (isJump || (isBranch && taken));
	assign redirectPc = isJump ? instr.j.target[`PC_WIDTH-1:0] :
		ifId.pcPlusOne + imm[`PC_WIDTH-1:0];
	assign haltFetch = ifId.valid && !stallDecode && ctrl.eop;

	// Source registers for hazards read as zero when unused
	assign rs = (ifId.valid && !isJump && !ctrl.eop) ? instr.r.rs : '0;
	assign rt = (ifId.valid && usesRt) ? instr.r.rt : '0;
	assign branch = ifId.valid && isBranch;

	// ID/EX register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;
		end else if (flushEx) begin
			idEx <= '0;
		end else begin
			idEx.valid <= ifId.valid;
			idEx.ctrl <= ifId.valid ? ctrl : '0;
			idEx.rs <= instr.r.rs;
			idEx.rt <= instr.r.rt;
			idEx.rd <= instr.r.rd;
			idEx.shamt <= instr.r.shamt;
			idEx.readA <= readA;
			idEx.readB <= readB;
			idEx.imm <= imm;
		end
	end

	// No delay slot so the next fetch is squashed
	assert property (@(posedge clk) disable iff (!rstN)
		redirect |=> !ifId.valid);

endmodule

/* decode/regFile.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module regFile (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
	input  logic                       writeEn,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	output logic [`DATA_WIDTH-1:0]     readDataA,
	output logic [`DATA_WIDTH-1:0]     readDataB
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle writeback seen by decode
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	// A stored register reads back on the next cycle
	assert property (@(posedge clk) disable iff (!rstN)
		(writeEn && writeAddr != '0) |=>
			(writeEn || readAddrA != $past(writeAddr) || readDataA == $past(writeData)));

endmodule

/* fetch/fetchStage.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module fetchStage (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   start,
	input  logic                   imemWe,
	input  logic [`PC_WIDTH-1:0]   imemAddr,
	input  logic [`DATA_WIDTH-1:0] imemData,
	input  logic                   stallFetch,
	input  logic                   redirect,
	input  logic [`PC_WIDTH-1:0]   redirectPc,
	input  logic                   haltFetch,
	output mipsPkg::ifIdT          ifId
);

	logic [`DATA_WIDTH-1:0] imem [`IMEM_DEPTH];
	logic [`PC_WIDTH-1:0]   pc;
	logic [`PC_WIDTH-1:0]   pcPlusOne;
	logic                   halt;
	logic                   fetchOff;

	// Program load port, works regardless of start
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Word addressed, so plus one
	assign pcPlusOne = pc + 1'b1;
	// Nothing fetched before start or once eop was decoded
	assign fetchOff = !start || halt || haltFetch;

	//////////////////////////////
	// Program counter
	//////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halt <= 1'b0;
		end else begin
			// Sticky until reset
			if (haltFetch) begin
				halt <= 1'b1;
			end
			// Taken branch or jump from decode
			if (redirect) begin
				pc <= redirectPc;
			end else if (!stallFetch && !fetchOff) begin
				pc <= pcPlusOne;
			end
		end
	end

	//////////////////////////////
	// IF/ID register
	//////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ifId <= '0;
		end else if (redirect || (fetchOff && !stallFetch)) begin
			// Squash wrong path, or bubble
			ifId.valid <= 1'b0;
		end else if (!stallFetch) begin
			ifId.valid <= 1'b1;
			ifId.instr <= imem[pc];
			ifId.pcPlusOne <= pcPlusOne;
		end
	end

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/1ns
`include "mips_config.svh"

module hazardUnit (
	input  logic [`REG_ADDR_WIDTH-1:0] rs,
	input  logic [`REG_ADDR_WIDTH-1:0] rt,
	input  logic                       branch,
	input  mipsPkg::idExT              idEx,
	input  logic [`REG_ADDR_WIDTH-1:0] writeRegEx,
	input  mipsPkg::exMemT             exMem,
	input  mipsPkg::memWbT             memWb,
	output logic                       stallFetch,
	output logic                       stallDecode,
	output logic                       flushEx,
	output logic                       fwdDecA,
	output logic                       fwdDecB,
	output mipsPkg::fwdSelT            fwdExA,
	output mipsPkg::fwdSelT            fwdExB
);

	logic exWrites;
	logic memWrites;
	logic wbWrites;
	logic exHitsDec;
	logic memHitsDec;
	logic loadUse;
	logic branchStall;
	logic stall;

	// Live producers per stage, r0 never counts
	assign exWrites = idEx.valid && idEx.ctrl.regWrite && (writeRegEx != '0);
	assign memWrites = exMem.valid && exMem.ctrl.regWrite && (exMem.writeReg != '0);
	assign wbWrites = memWb.valid && memWb.regWrite && (memWb.writeReg != '0);

	//////////////////////////////
	// Forwarding
	//////////////////////////////

	// Newest value wins, memory before writeback
	assign fwdExA = (memWrites && exMem.writeReg == idEx.rs) ? mipsPkg::FWD_MEM :
		(wbWrites && memWb.writeReg == idEx.rs) ? mipsPkg::FWD_WB : mipsPkg::FWD_REG;
	assign fwdExB = (memWrites && exMem.writeReg == idEx.rt) ? mipsPkg::FWD_MEM :
		(wbWrites && memWb.writeReg == idEx.rt) ? mipsPkg::FWD_WB : mipsPkg::FWD_REG;

	// Branch compare in decode, only from the memory stage
	// Writeback comes through the register file bypass
	assign fwdDecA = memWrites && (exMem.writeReg == rs);
	assign fwdDecB = memWrites && (exMem.writeReg == rt);

	//////////////////////////////
	// Stalls
	//////////////////////////////

	// Decode rs/rt read as zero when not sources
	assign exHitsDec = exWrites && (writeRegEx == rs || writeRegEx == rt);
	assign memHitsDec = memWrites && (exMem.writeReg == rs || exMem.writeReg == rt);

	// Load result not ready until writeback
	assign loadUse = exHitsDec && idEx.ctrl.memToReg;
	// Any producer in execute, or a load still in memory
	assign branchStall = branch && (exHitsDec || (memHitsDec && exMem.ctrl.memToReg));

	assign stall = loadUse || branchStall;
	assign stallFetch = stall;
	assign stallDecode = stall;
	// Bubble into ID/EX while decode holds
	assign flushEx = stall;

endmodule

/* common/mipsPkg.sv */
`include "mips_config.svh"

package mipsPkg;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Major opcodes, eop uses the last code
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		OP_RTYPE = 6'h00, OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05,
		OP_ADDI = 6'h08, OP_ANDI = 6'h0C, OP_ORI = 6'h0D, OP_LUI = 6'h0F,
		OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_SW = 6'h2B,
		OP_EOP = 6'h3F
	} opcodeT;

	// R-type function codes
	typedef enum logic [`FUNCT_WIDTH-1:0] {
		FN_SLL = 6'h00, FN_ADD = 6'h20, FN_SUB = 6'h22,
		FN_AND = 6'h24, FN_OR = 6'h25, FN_SLT = 6'h2A
	} functT;

	// Add is zero, so a cleared control word adds
	typedef enum logic [3:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} aluOpT;
	typedef enum logic [1:0] {LOAD_WORD, LOAD_HALF, LOAD_BYTE} loadWidthT;
	// Execute operand sources
	typedef enum logic [1:0] {FWD_REG, FWD_WB, FWD_MEM} fwdSelT;

	//////////////////////////////
	// Instruction word
	//////////////////////////////

	typedef struct packed {
		opcodeT                     opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`REG_ADDR_WIDTH-1:0] shamt;
		functT                      funct;
	} rTypeT;

	typedef struct packed {
		opcodeT                     opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`IMM_WIDTH-1:0]      imm;
	} iTypeT;

	typedef struct packed {
		opcodeT                                opcode;
		logic [`DATA_WIDTH-`OPCODE_WIDTH-1:0] target;
	} jTypeT;

	// Same 32 bits, three views
	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

	//////////////////////////////
	// Control and pipeline registers
	//////////////////////////////

	typedef struct packed {
		aluOpT     aluOp;
		logic      aluSrc;
		logic      aluShiftImm;
		logic      loadImm;
		logic      regDst;
		logic      memWrite;
		logic      memToReg;
		loadWidthT loadWidth;
		logic      regWrite;
		logic      eop;
	} ctrlT;

	typedef struct packed {
		logic                 valid;
		instrT                instr;
		logic [`PC_WIDTH-1:0] pcPlusOne;
	} ifIdT;

	typedef struct packed {
		logic                       valid;
		ctrlT                       ctrl;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`REG_ADDR_WIDTH-1:0] shamt;
		logic [`DATA_WIDTH-1:0]     readA;
		logic [`DATA_WIDTH-1:0]     readB;
		logic [`DATA_WIDTH-1:0]     imm;
	} idExT;

	// Only memory and writeback control fields matter past execute
	typedef struct packed {
		logic                       valid;
		ctrlT                       ctrl;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
		logic [`DATA_WIDTH-1:0]     aluOut;
		logic [`DATA_WIDTH-1:0]     storeData;
	} exMemT;

	typedef struct packed {
		logic                       valid;
		logic                       regWrite;
		logic                       eop;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
		logic [`DATA_WIDTH-1:0]     result;
	} memWbT;

endpackage

/* common/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath widths
`define DATA_WIDTH 32
`define PC_WIDTH 8
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Memory depths, in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Instruction fields
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define IMM_WIDTH 16
// Shift amount for lui
`define LUI_SHIFT 16

`endif
